/* sources.f */
+incdir+common
common/sprite_pkg.sv
timing/display_timing.sv
sprite/sprite_store.sv
sprite/sprite_engine.sv
logic/pixel_output.sv
logic/sprite_display_top.sv
bench/tb_sprite_display.sv

/* Makefile */
# Verilator build and run for the sprite display testbench

VERILATOR ?= verilator
TOP       ?= tb_sprite_display
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= TESTS PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard common/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run check clean

all: run

build: $(BIN)

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@$(MAKE) --no-print-directory check LOG=$(LOG)

check:
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "Simulation result found in $(LOG)"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/tb_sprite_display.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the sprite display top level
// Raster timing, sprite pixels, position and bitmap
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "video_defs.svh"

module tb_sprite_display;
    import sprite_pkg::*;

    localparam int     CLK_PERIOD  = 40;
    localparam int     DRIVE_DLY   = 1;    // Input skew after the rising edge
    localparam longint WATCHDOG_NS = (5 * `H_TOTAL * `V_TOTAL + 20000) * CLK_PERIOD;

    logic     clk_pix;
    logic     reset;
    logic     bmp_wr_en;
    logic [2:0] bmp_wr_addr;
    spr_row_t bmp_wr_data;
    coord_t   spr_x;
    coord_t   spr_y;
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
    logic     hsync_out;
    logic     vsync_out;
    logic     de_out;

    spr_row_t [`SPR_HEIGHT-1:0] bmp_model;   // Mirror of every row written
    spr_row_t [`SPR_HEIGHT-1:0] bmp_frame;   // Rows in effect for the current frame
    logic [31:0] rng_state;
    int       ref_x;                        // Position latched for the current frame
    int       ref_y;
    int       x_pos;                        // Beam position seen at the outputs
    int       y_pos;
    int       frame_cnt;
    bit       new_frame;
    int       de_run;
    int       hs_run;
    int       vs_run;
    int       pix_checks;
    int       n_checks;
    int       n_errors;
    rgb_t     exp_rgb;

    sprite_display_top sprite_display_top_inst (
        .clk_pix     (clk_pix),
        .reset       (reset),
        .bmp_wr_en   (bmp_wr_en),
        .bmp_wr_addr (bmp_wr_addr),
        .bmp_wr_data (bmp_wr_data),
        .spr_x       (spr_x),
        .spr_y       (spr_y),
        .red         (red),
        .green       (green),
        .blue        (blue),
        .hsync_out   (hsync_out),
        .vsync_out   (vsync_out),
        .de_out      (de_out)
    );

    always #(CLK_PERIOD / 2) clk_pix = ~clk_pix;

    // 32-bit xorshift
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // Expected colour of one active pixel
    function automatic rgb_t expected_rgb(input int x, input int y, input int px, input int py,
                                          input spr_row_t [`SPR_HEIGHT-1:0] bmp);
        int    dx;
        int    dy;
        cidx_t idx;
        dx = x - px;
        dy = y - py;
        if (x >= `H_ACTIVE || dx < 0 || dx >= `SPR_WIDTH || dy < 0 || dy >= `SPR_HEIGHT) begin
            return BG_COLOUR;    // Outside the box
        end
        idx = bmp[dy][dx*CIDX_W +: CIDX_W];
        if (idx == 2'd0) begin
            return BG_COLOUR;    // Transparent
        end
        return PALETTE[idx];
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("FAIL t=%0t %s expected 0x%0h actual 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic write_row(input logic [2:0] row, input spr_row_t data);
        @(posedge clk_pix);
        #(DRIVE_DLY);
        bmp_wr_en   = 1'b1;
        bmp_wr_addr = row;
        bmp_wr_data = data;
        bmp_model[row] = data;
        @(posedge clk_pix);
        #(DRIVE_DLY);
        bmp_wr_en = 1'b0;
    endtask

    task automatic load_bitmap();
        spr_row_t data;
        for (int r = 0; r < `SPR_HEIGHT; r++) begin
            rng_state = xorshift32(rng_state);
            data = rng_state[15:0];
            if (r == 3) begin
                data = data & 16'h0FF0;    // Pixels 0, 1, 6, 7 transparent
            end
            write_row(3'(r), data);
        end
    endtask

    // Output monitor sampled on the falling edge
    always @(negedge clk_pix) begin
        if (!reset) begin
            if (hsync_out == 1'b0) begin
                hs_run++;
            end else if (hs_run != 0) begin
                check_value("hsync_low_run", 32'(`H_SYNC), 32'(hs_run));
                hs_run = 0;
            end
            if (vsync_out == 1'b0) begin
                if (vs_run == 0 && frame_cnt > 0) begin
                    check_value("active_lines", 32'(`V_ACTIVE), 32'(y_pos));
                end
                vs_run++;
                y_pos     = 0;
                x_pos     = 0;
                new_frame = 1'b1;
            end else if (vs_run != 0) begin
                check_value("vsync_low_run", 32'(`V_SYNC * `H_TOTAL), 32'(vs_run));
                vs_run = 0;
            end
            if (de_out) begin
                if (new_frame) begin
                    bmp_frame = bmp_model;    // Snapshot at first active pixel
                    ref_x     = int'(spr_x);
                    ref_y     = int'(spr_y);
                    frame_cnt++;
                    new_frame = 1'b0;
                end
                if (frame_cnt >= 2) begin
                    exp_rgb = expected_rgb(x_pos, y_pos, ref_x, ref_y, bmp_frame);
                    check_value($sformatf("rgb(%0d,%0d)", x_pos, y_pos),
                                32'(exp_rgb), 32'({red, green, blue}));
                    pix_checks++;
                end
                x_pos++;
                de_run++;
            end else begin
                if (frame_cnt >= 2) begin
                    check_value("rgb_blank", 32'd0, 32'({red, green, blue}));
                end
                if (de_run != 0) begin
                    check_value("active_run", 32'(`H_ACTIVE), 32'(de_run));
                    de_run = 0;
                    x_pos  = 0;
                    y_pos++;
                end
            end
        end
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: simulation still running after %0d ns", WATCHDOG_NS);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        clk_pix     = 1'b0;
        reset       = 1'b1;
        bmp_wr_en   = 1'b0;
        bmp_wr_addr = '0;
        bmp_wr_data = '0;
        spr_x       = 16'sd100;
        spr_y       = 16'sd50;
        bmp_model   = '0;
        bmp_frame   = '0;
        rng_state   = 32'd10;
        x_pos       = 0;
        y_pos       = 0;
        frame_cnt   = 0;
        de_run      = 0;
        hs_run      = 0;
        vs_run      = 0;
        pix_checks  = 0;
        n_checks    = 0;
        n_errors    = 0;
        ref_x       = 0;
        ref_y       = 0;
        new_frame   = 1'b1;    // First frame has no vsync before it

        repeat (5) @(posedge clk_pix);
        #(DRIVE_DLY);
        reset = 1'b0;
        @(posedge clk_pix);    // First edge with reset low
        @(negedge clk_pix);    // First output cycle out of reset
        check_value("de_out", 32'd0, 32'(de_out));
        check_value("hsync_out", 32'd1, 32'(hsync_out));
        check_value("vsync_out", 32'd1, 32'(vsync_out));

        load_bitmap();    // Frame 1 is not compared

        // Mid-frame move in frame 3 puts frame 4 near the right edge
        wait (frame_cnt == 3 && y_pos == 240);
        @(posedge clk_pix);
        #(DRIVE_DLY);
        spr_x = 16'sd636;
        spr_y = 16'sd300;

        // Row 5 inverted during frame 4 blanking
        wait (frame_cnt == 4 && vsync_out == 1'b0);
        write_row(3'd5, ~bmp_model[5]);

        wait (frame_cnt == 5 && vsync_out == 1'b0);
        repeat (4) @(posedge clk_pix);
        check_value("pixels_checked", 32'(4 * `H_ACTIVE * `V_ACTIVE), 32'(pix_checks));

        $display("Summary: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* logic/sprite_display_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sprite display top level
// Timing, bitmap store, sprite engine, output stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module sprite_display_top (
    input  logic                 clk_pix,
    input  logic                 reset,
    input  logic                 bmp_wr_en,
    input  logic [2:0]           bmp_wr_addr,
    input  sprite_pkg::spr_row_t bmp_wr_data,
    input  sprite_pkg::coord_t   spr_x,
    input  sprite_pkg::coord_t   spr_y,
    output logic [7:0]           red,
    output logic [7:0]           green,
    output logic [7:0]           blue,
    output logic                 hsync_out,
    output logic                 vsync_out,
    output logic                 de_out
);
    import sprite_pkg::*;

    // Raster from the timing generator
    coord_t   sx;
    coord_t   sy;
    logic     hsync;
    logic     vsync;
    logic     de;
    logic     line_start;
    logic     frame_start;

    // Row read port between engine and store
    logic     rd_en;
    logic [2:0] rd_addr;
    spr_row_t rd_data;

    cidx_t    spr_pix;    // One cycle behind sx

    display_timing display_timing_inst (
        .clk_pix     (clk_pix),
        .reset       (reset),
        .sx          (sx),
        .sy          (sy),
        .hsync       (hsync),
        .vsync       (vsync),
        .de          (de),
        .line_start  (line_start),
        .frame_start (frame_start)
    );

    sprite_store sprite_store_inst (
        .clk_pix (clk_pix),
        .wr_en   (bmp_wr_en),
        .wr_addr (bmp_wr_addr),
        .wr_data (bmp_wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    sprite_engine sprite_engine_inst (
        .clk_pix     (clk_pix),
        .reset       (reset),
        .sx          (sx),
        .sy          (sy),
        .de          (de),
        .line_start  (line_start),
        .frame_start (frame_start),
        .spr_x       (spr_x),
        .spr_y       (spr_y),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .spr_pix     (spr_pix)
    );

    // Two cycles from timing generator to pins
    pixel_output pixel_output_inst (
        .clk_pix   (clk_pix),
        .reset     (reset),
        .spr_pix   (spr_pix),
        .hsync     (hsync),
        .vsync     (vsync),
        .de        (de),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .hsync_out (hsync_out),
        .vsync_out (vsync_out),
        .de_out    (de_out)
    );

endmodule

/* logic/pixel_output.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pixel output stage
// Palette lookup, blanking and sync alignment
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "video_defs.svh"

module pixel_output (
    input  logic              clk_pix,
    input  logic              reset,
    input  sprite_pkg::cidx_t spr_pix,
    input  logic              hsync,
    input  logic              vsync,
    input  logic              de,
    output logic [7:0]        red,
    output logic [7:0]        green,
    output logic [7:0]        blue,
    output logic              hsync_out,
    output logic              vsync_out,
    output logic              de_out
);
    import sprite_pkg::*;

    logic hsync_d;    // First delay stage, lines up with spr_pix
    logic vsync_d;
    logic de_d;
    rgb_t pix_rgb;

    // Palette lookup, index 0 falls through to background
    always_comb begin
        case (spr_pix)
            2'd1:    pix_rgb = PALETTE[1];
            2'd2:    pix_rgb = PALETTE[2];
            2'd3:    pix_rgb = PALETTE[3];
            default: pix_rgb = BG_COLOUR;
        endcase
        if (!de_d) begin
            pix_rgb = '0;    // Black in blanking
        end
    end

    // Two-stage sync delay
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            hsync_d   <= ~`SYNC_ACTIVE;
            vsync_d   <= ~`SYNC_ACTIVE;
            de_d      <= 1'b0;
            hsync_out <= ~`SYNC_ACTIVE;
            vsync_out <= ~`SYNC_ACTIVE;
            de_out    <= 1'b0;
        end else begin
            hsync_d   <= hsync;
            vsync_d   <= vsync;
            de_d      <= de;
            hsync_out <= hsync_d;
            vsync_out <= vsync_d;
            de_out    <= de_d;
        end
    end

    // Colour registers, same cycle as the second sync stage
    always_ff @(posedge clk_pix) begin
        red   <= pix_rgb.red;
        green <= pix_rgb.green;
        blue  <= pix_rgb.blue;
    end

endmodule

/* sprite/sprite_engine.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sprite engine, one row fetch per scan line
// Shifts out a colour index per pixel at the sprite
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "video_defs.svh"

module sprite_engine (
    input  logic                 clk_pix,
    input  logic                 reset,
    input  sprite_pkg::coord_t   sx,
    input  sprite_pkg::coord_t   sy,
    input  logic                 de,
    input  logic                 line_start,
    input  logic                 frame_start,
    input  sprite_pkg::coord_t   spr_x,
    input  sprite_pkg::coord_t   spr_y,
    output logic                 rd_en,
    output logic [2:0]           rd_addr,
    input  sprite_pkg::spr_row_t rd_data,
    output sprite_pkg::cidx_t    spr_pix
);
    import sprite_pkg::*;

    localparam int CNT_W = $clog2(`SPR_WIDTH + 1);

    coord_t           x_lat;      // Position for the current frame
    coord_t           y_lat;
    coord_t           x_cur;
    coord_t           y_cur;
    coord_t           dy;         // Line offset into the sprite
    logic             fetch_d;    // rd_data valid this cycle
    spr_row_t         shifter;
    logic [CNT_W-1:0] draw_cnt;   // Pixels left after the current one
    logic             draw_start;
    logic             draw_on;

    // Position sampled once per frame
    always_ff @(posedge clk_pix) begin
        if (frame_start) begin
            x_lat <= spr_x;
            y_lat <= spr_y;
        end
    end

    // Frame start shares its cycle with the first line start,
    // so the new position is used directly there
    assign x_cur = frame_start ? spr_x : x_lat;
    assign y_cur = frame_start ? spr_y : y_lat;
    assign dy    = sy - y_cur;

    // Row fetch at line start when the line crosses the sprite
    assign rd_en   = line_start && (dy >= 0) && (dy < `SPR_HEIGHT);
    assign rd_addr = dy[2:0];

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            fetch_d <= 1'b0;
        end else begin
            fetch_d <= rd_en;    // Store answers one cycle later
        end
    end

    // Draw window opens when the beam reaches the sprite column
    // Row lands two cycles after line start, so x must be 2 or more
    assign draw_start = de && (sx == x_cur) && (draw_cnt == '0);
    assign draw_on    = de && (draw_start || (draw_cnt != '0));

    // Pixel shifter, pixel 0 leaves first
    always_ff @(posedge clk_pix) begin
        if (reset || line_start) begin
            shifter <= '0;    // Lines without a fetch stay transparent
        end else if (fetch_d) begin
            shifter <= rd_data;
        end else if (draw_on) begin
            shifter <= shifter >> CIDX_W;
        end
    end

    // Index output and pixel count
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            draw_cnt <= '0;
            spr_pix  <= '0;
        end else begin
            spr_pix <= draw_on ? shifter[CIDX_W-1:0] : '0;
            if (!de) begin
                draw_cnt <= '0;    // Cut off at end of active video, no wrap
            end else if (draw_start) begin
                draw_cnt <= CNT_W'(`SPR_WIDTH - 1);
            end else if (draw_cnt != '0) begin
                draw_cnt <= draw_cnt - 1'b1;
            end
        end
    end

endmodule

/* sprite/sprite_store.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sprite bitmap store, one entry per row
// Synchronous write, registered read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "video_defs.svh"

module sprite_store (
    input  logic                 clk_pix,
    input  logic                 wr_en,
    input  logic [2:0]           wr_addr,
    input  sprite_pkg::spr_row_t wr_data,
    input  logic                 rd_en,
    input  logic [2:0]           rd_addr,
    output sprite_pkg::spr_row_t rd_data
);
    import sprite_pkg::*;

    // Row memory, contents come from the write port only
    spr_row_t mem [`SPR_HEIGHT];

    // Write port
    // Accepted on any cycle with wr_en high
    always_ff @(posedge clk_pix) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read port, data one cycle after rd_en
    // Same-row write in the same cycle returns the old row
    always_ff @(posedge clk_pix) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* timing/display_timing.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Display timing generator for 640x480
// Raster position, syncs, data enable and strobes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "video_defs.svh"

module display_timing (
    input  logic               clk_pix,
    input  logic               reset,
    output sprite_pkg::coord_t sx,
    output sprite_pkg::coord_t sy,
    output logic               hsync,
    output logic               vsync,
    output logic               de,
    output logic               line_start,
    output logic               frame_start
);
    import sprite_pkg::*;

    // Sync windows, active video first then porch, sync, porch
    localparam int HS_START = `H_ACTIVE + `H_FRONT;
    localparam int HS_END   = HS_START + `H_SYNC;
    localparam int VS_START = `V_ACTIVE + `V_FRONT;
    localparam int VS_END   = VS_START + `V_SYNC;

    coord_t h_cnt;    // Runs one cycle ahead of sx
    coord_t v_cnt;
    logic   hs_on;
    logic   vs_on;

    assign hs_on = (h_cnt >= HS_START) && (h_cnt < HS_END);
    assign vs_on = (v_cnt >= VS_START) && (v_cnt < VS_END);

    // Raster counters
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == coord_t'(`H_TOTAL - 1)) begin
            h_cnt <= '0;    // Next line
            if (v_cnt == coord_t'(`V_TOTAL - 1)) begin
                v_cnt <= '0;    // Next frame
            end else begin
                v_cnt <= v_cnt + coord_t'(1);
            end
        end else begin
            h_cnt <= h_cnt + coord_t'(1);
        end
    end

    // Output registers
    // First cycle out of reset presents position 0,0 with both strobes
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sx          <= '0;
            sy          <= '0;
            hsync       <= ~`SYNC_ACTIVE;    // Held inactive
            vsync       <= ~`SYNC_ACTIVE;
            de          <= 1'b0;
            line_start  <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            sx          <= h_cnt;
            sy          <= v_cnt;
            hsync       <= hs_on ? `SYNC_ACTIVE : ~`SYNC_ACTIVE;
            vsync       <= vs_on ? `SYNC_ACTIVE : ~`SYNC_ACTIVE;   // Whole lines
            de          <= (h_cnt < `H_ACTIVE) && (v_cnt < `V_ACTIVE);
            line_start  <= (h_cnt == '0);
            frame_start <= (h_cnt == '0) && (v_cnt == '0);
        end
    end

endmodule

/* common/sprite_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types for the sprite display
// Coordinates, colour indices, bitmap rows, palette
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "video_defs.svh"

package sprite_pkg;

    localparam int CORD_W = 16;    // Screen coordinate width
    localparam int CIDX_W = 2;     // Bits per colour index

    typedef logic signed [CORD_W-1:0] coord_t;   // Signed so off-screen positions work
    typedef logic [CIDX_W-1:0] cidx_t;           // Index 0 is transparent

    // One bitmap row, pixel 0 in the low bits
    typedef logic [`SPR_WIDTH*CIDX_W-1:0] spr_row_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    // Colours for indices 1 to 3
    localparam rgb_t PALETTE [1:3] = '{
        '{red: 8'hFF, green: 8'hCC, blue: 8'h00},   // Amber
        '{red: 8'h00, green: 8'hC0, blue: 8'hFF},   // Cyan
        '{red: 8'hF0, green: 8'hF0, blue: 8'hF0}    // Near white
    };

    // Shown wherever no sprite pixel lands
    localparam rgb_t BG_COLOUR = '{red: 8'h10, green: 8'h20, blue: 8'h48};

endpackage

/* common/video_defs.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Video mode timing and sprite geometry macros
// 640x480 at 60 Hz, one 8x8 sprite
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

// Horizontal timing in pixels
`define H_ACTIVE 640
`define H_FRONT  16
`define H_SYNC   96
`define H_BACK   48
`define H_TOTAL  (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)   // 800 pixels per line

// Vertical timing in lines
`define V_ACTIVE 480
`define V_FRONT  10
`define V_SYNC   2
`define V_BACK   33
`define V_TOTAL  (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)   // 525 lines per frame

// Both syncs negative in this mode
`define SYNC_ACTIVE 1'b0

// Sprite size
`define SPR_WIDTH  8    // Pixels per row
`define SPR_HEIGHT 8    // Rows

`endif
